// File: common/bpu_defines.svh
`ifndef BPU_DEFINES_SVH
`define BPU_DEFINES_SVH

// datapath and history
`define BPU_XLEN        32
`define BPU_HIST_W      16

// direction predictor geometry
`define BPU_BIM_IDX_W   9   // 512 bimodal entries
`define BPU_TAGE_IDX_W  8   // 256 entries per tagged bank
`define BPU_TAG_W       10
`define BPU_PTAG_W      6   // only the upper tag bits are compared
`define BPU_NUM_BANKS   2

// target buffer
`define BPU_BTB_IDX_W   8
`define BPU_BTB_TAG_W   14

// return stack
`define BPU_RAS_DEPTH   32

// rv32 control transfer opcodes
`define BPU_OP_BRANCH   7'b1100011
`define BPU_OP_JAL      7'b1101111
`define BPU_OP_JALR     7'b1100111

`endif

// File: common/bpu_pkg.sv
`include "bpu_defines.svh"

package bpu_pkg;

    // b-type field layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // j-type field layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } inst_u;

    typedef logic [1:0] ctr_t;  // 2-bit saturating counter

    typedef struct packed {
        logic [`BPU_TAGE_IDX_W-1:0] idx;
        logic [`BPU_TAG_W-1:0]      tag;
    } bank_key_t;

    typedef struct packed {
        logic hit;
        logic ctr_hi;   // direction of the matching entry
    } bank_hit_t;

    typedef enum logic [1:0] {
        UPD_TRAIN,
        UPD_RESET,
        UPD_ALLOC
    } upd_mode_e;

    typedef struct packed {
        logic      en;
        upd_mode_e mode;
        logic      taken;
    } bank_upd_t;

    // resolved control transfer from execute
    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic                   pdt_true;
        logic [`BPU_XLEN-1:0]   pc;
        logic [`BPU_HIST_W-1:0] hist;
        logic [`BPU_XLEN-1:0]   target;
        logic [`BPU_XLEN-1:0]   inst;
    } ex_fb_t;

    typedef struct packed {
        logic branch;
        logic jal;
        logic jalr;
        logic call;
        logic ret;
    } inst_class_t;

    function automatic inst_class_t classify(input logic [`BPU_XLEN-1:0] inst);
        inst_u       iw;
        inst_class_t c;
        iw = inst;
        c.branch = (iw.j.opcode == `BPU_OP_BRANCH);
        c.jal    = (iw.j.opcode == `BPU_OP_JAL);
        c.jalr   = (iw.j.opcode == `BPU_OP_JALR);
        c.ret    = c.jalr && (iw.j.rd == 5'd0) && (iw.b.rs1 == 5'd1);
        c.call   = c.jal || (c.jalr && (iw.j.rd != 5'd0));
        return c;
    endfunction

    // per-bank index and tag folding
    function automatic bank_key_t bank_hash(input logic [`BPU_XLEN-1:0] pc,
                                            input logic [`BPU_HIST_W-1:0] hist,
                                            input int bank);
        bank_key_t k;
        if (bank == 0) begin
            k.idx = pc[7:0] ^ hist[7:0];
            k.tag = pc[17:8] ^ hist[15:6];
        end else begin
            k.idx = pc[7:0] ^ hist[15:8];
            k.tag = pc[17:8] ^ {2'b00, hist[7:0]};
        end
        return k;
    endfunction

    function automatic ctr_t ctr_train(input ctr_t c, input logic taken);
        if (taken)
            return (c == 2'b11) ? c : c + 2'd1;
        else
            return (c == 2'b00) ? c : c - 2'd1;
    endfunction

endpackage

// File: tage/tage_hash.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module tage_hash (
    input  logic                                       clk,
    input  logic                                       rst,
    input  bpu_pkg::ex_fb_t                            fb_i,
    input  logic [`BPU_XLEN-1:0]                       if_pc_i,
    output bpu_pkg::bank_key_t [`BPU_NUM_BANKS-1:0]    lkp_key_o,
    output bpu_pkg::bank_key_t [`BPU_NUM_BANKS-1:0]    upd_key_o,
    output logic [`BPU_BIM_IDX_W-1:0]                  bim_lkp_idx_o,
    output logic [`BPU_BIM_IDX_W-1:0]                  bim_upd_idx_o,
    output logic [`BPU_HIST_W-1:0]                     history_o
);
    import bpu_pkg::*;

    logic [`BPU_HIST_W-1:0] ghist_q;

    // one outcome bit per resolved transfer, newest in bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (fb_i.valid) begin
            ghist_q <= {ghist_q[`BPU_HIST_W-2:0], fb_i.taken};
        end
    end

    assign history_o = ghist_q;

    // fetch side uses live history, execute side the history it was predicted with
    always_comb begin
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            lkp_key_o[b] = bank_hash(if_pc_i, ghist_q, b);
            upd_key_o[b] = bank_hash(fb_i.pc, fb_i.hist, b);
        end
    end

    assign bim_lkp_idx_o = if_pc_i[`BPU_BIM_IDX_W:1];
    assign bim_upd_idx_o = fb_i.pc[`BPU_BIM_IDX_W:1];  // bit 0 always zero

endmodule

// File: tage/tage_bank.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module tage_bank (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::bank_key_t  lkp_key_i,
    input  bpu_pkg::bank_key_t  upd_key_i,
    input  bpu_pkg::bank_upd_t  upd_i,
    output bpu_pkg::bank_hit_t  lkp_hit_o,
    output bpu_pkg::bank_hit_t  upd_hit_o
);
    import bpu_pkg::*;

    localparam int ENTRIES = 1 << `BPU_TAGE_IDX_W;

    logic [`BPU_TAG_W-1:0] tag_q [ENTRIES];
    ctr_t                  ctr_q [ENTRIES];

    // partial tag compare on the upper bits
    assign lkp_hit_o.hit = tag_q[lkp_key_i.idx][`BPU_TAG_W-1 -: `BPU_PTAG_W] ==
                           lkp_key_i.tag[`BPU_TAG_W-1 -: `BPU_PTAG_W];
    assign lkp_hit_o.ctr_hi = ctr_q[lkp_key_i.idx][1];

    assign upd_hit_o.hit = tag_q[upd_key_i.idx][`BPU_TAG_W-1 -: `BPU_PTAG_W] ==
                           upd_key_i.tag[`BPU_TAG_W-1 -: `BPU_PTAG_W];
    assign upd_hit_o.ctr_hi = ctr_q[upd_key_i.idx][1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= 2'b01;  // weakly not taken
            end
        end else if (upd_i.en) begin
            case (upd_i.mode)
                UPD_TRAIN: begin
                    ctr_q[upd_key_i.idx] <= ctr_train(ctr_q[upd_key_i.idx], upd_i.taken);
                end
                UPD_RESET: begin
                    ctr_q[upd_key_i.idx] <= upd_i.taken ? 2'b11 : 2'b00;
                end
                UPD_ALLOC: begin
                    // new entry starts weak in the resolved direction
                    tag_q[upd_key_i.idx] <= upd_key_i.tag;
                    ctr_q[upd_key_i.idx] <= upd_i.taken ? 2'b10 : 2'b01;
                end
                default: begin
                    ctr_q[upd_key_i.idx] <= ctr_q[upd_key_i.idx];
                end
            endcase
        end
    end

endmodule

// File: tage/tage_select.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module tage_select (
    input  logic                                    clk,
    input  logic                                    rst,
    input  bpu_pkg::ex_fb_t                         fb_i,
    input  logic [`BPU_BIM_IDX_W-1:0]               bim_lkp_idx_i,
    input  logic [`BPU_BIM_IDX_W-1:0]               bim_upd_idx_i,
    input  bpu_pkg::bank_hit_t [`BPU_NUM_BANKS-1:0] lkp_hit_i,
    input  bpu_pkg::bank_hit_t [`BPU_NUM_BANKS-1:0] upd_hit_i,
    output bpu_pkg::bank_upd_t [`BPU_NUM_BANKS-1:0] upd_o,
    output logic                                    dir_taken_o
);
    import bpu_pkg::*;

    localparam int BIM_ENTRIES = 1 << `BPU_BIM_IDX_W;

    ctr_t        bim_q [BIM_ENTRIES];
    inst_class_t ex_cls;

    assign ex_cls = classify(fb_i.inst);

    // base table trains on every resolution
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIM_ENTRIES; i++) begin
                bim_q[i] <= 2'b01;
            end
        end else if (fb_i.valid) begin
            bim_q[bim_upd_idx_i] <= ctr_train(bim_q[bim_upd_idx_i], fb_i.taken);
        end
    end

    // highest matching bank wins, bimodal as fallback
    always_comb begin
        dir_taken_o = bim_q[bim_lkp_idx_i][1];
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            if (lkp_hit_i[b].hit) dir_taken_o = lkp_hit_i[b].ctr_hi;
        end
    end

    // provider rebuilt from the execute pc and its returned history
    always_comb begin
        int prov;
        prov = -1;  // -1 is the bimodal table
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            if (upd_hit_i[b].hit) prov = b;
        end
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            upd_o[b].en    = 1'b0;
            upd_o[b].mode  = UPD_TRAIN;
            upd_o[b].taken = fb_i.taken;
            if (fb_i.valid && ex_cls.branch) begin
                if (b == prov) begin
                    upd_o[b].en   = 1'b1;
                    upd_o[b].mode = fb_i.pdt_true ? UPD_TRAIN : UPD_RESET;
                end else if (!fb_i.pdt_true && b == prov + 1) begin
                    upd_o[b].en   = 1'b1;   // grab an entry one bank up
                    upd_o[b].mode = UPD_ALLOC;
                end
            end
        end
    end

endmodule

// File: rtl/btb.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module btb (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::ex_fb_t      fb_i,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    output logic                 hit_o,
    output logic [`BPU_XLEN-1:0] target_o
);
    import bpu_pkg::*;

    localparam int ENTRIES = 1 << `BPU_BTB_IDX_W;

    logic                      valid_q [ENTRIES];
    logic [`BPU_BTB_TAG_W-1:0] tag_q   [ENTRIES];
    logic [`BPU_XLEN-1:0]      tgt_q   [ENTRIES];

    logic [`BPU_BTB_IDX_W-1:0] rd_idx, wr_idx;
    inst_class_t               ex_cls;
    logic                      wr_en;

    assign rd_idx = if_pc_i[`BPU_BTB_IDX_W+1:2];
    assign wr_idx = fb_i.pc[`BPU_BTB_IDX_W+1:2];

    assign hit_o    = valid_q[rd_idx] &&
                      (tag_q[rd_idx] == if_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W]);
    assign target_o = tgt_q[rd_idx];

    assign ex_cls = classify(fb_i.inst);
    assign wr_en  = fb_i.valid && fb_i.taken && (ex_cls.branch || ex_cls.jal || ex_cls.jalr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx] <= fb_i.pc[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];
            tgt_q[wr_idx] <= fb_i.target;
        end
    end

endmodule

// File: rtl/ras.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module ras #(
    parameter int DEPTH = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::ex_fb_t      fb_i,
    output logic                 nonempty_o,
    output logic [`BPU_XLEN-1:0] top_o
);
    import bpu_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [`BPU_XLEN-1:0] stack_q [DEPTH];
    logic [AW:0]          ptr_q;    // number of live entries
    logic [AW-1:0]        top_idx;
    inst_class_t          ex_cls;

    assign ex_cls = classify(fb_i.inst);

    // wraps to the last slot when full, which is the top then
    assign top_idx    = ptr_q[AW-1:0] - AW'(1);
    assign nonempty_o = (ptr_q != '0);
    assign top_o      = stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (fb_i.valid) begin
            if (ex_cls.call) begin
                ptr_q <= (ptr_q < DEPTH) ? ptr_q + 1'b1 : (AW+1)'(1);  // overflow restarts at 1
            end else if (ex_cls.ret && ptr_q != '0) begin
                ptr_q <= ptr_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fb_i.valid && ex_cls.call) begin
            if (ptr_q < DEPTH)
                stack_q[ptr_q[AW-1:0]] <= fb_i.pc + 32'd4;
            else
                stack_q[0] <= fb_i.pc + 32'd4;
        end
    end

endmodule

// File: rtl/next_pc_sel.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module next_pc_sel (
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    input  logic                 dir_taken_i,
    input  logic                 btb_hit_i,
    input  logic [`BPU_XLEN-1:0] btb_target_i,
    input  logic                 ras_nonempty_i,
    input  logic [`BPU_XLEN-1:0] ras_top_i,
    output logic                 branch_or_not_o,
    output logic [`BPU_XLEN-1:0] pdt_pc_o,
    output logic                 pdt_res_o
);
    import bpu_pkg::*;

    inst_u                iw;
    inst_class_t          cls;
    logic [`BPU_XLEN-1:0] b_imm;
    logic [`BPU_XLEN-1:0] j_imm;
    logic [`BPU_XLEN-1:0] seq_pc;
    logic                 direct_taken;

    assign iw  = if_inst_i;
    assign cls = classify(if_inst_i);

    // sign-extended immediates, bit 0 implied zero
    assign b_imm = {{20{iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
    assign j_imm = {{12{iw.j.imm20}}, iw.j.imm19_12, iw.j.imm11, iw.j.imm10_1, 1'b0};

    assign seq_pc       = if_pc_i + 32'd4;
    assign direct_taken = cls.jal || (cls.branch && dir_taken_i);

    assign branch_or_not_o = cls.branch || cls.jal || cls.jalr;

    always_comb begin
        pdt_res_o = 1'b0;
        pdt_pc_o  = seq_pc;
        if (cls.ret) begin
            if (ras_nonempty_i) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = ras_top_i;
            end else if (btb_hit_i) begin
                pdt_res_o = 1'b1;   // empty stack, last seen target
                pdt_pc_o  = btb_target_i;
            end
        end else if (cls.jalr) begin
            if (btb_hit_i) begin    // register target, only btb knows it
                pdt_res_o = 1'b1;
                pdt_pc_o  = btb_target_i;
            end
        end else if (direct_taken) begin
            pdt_res_o = 1'b1;
            if (btb_hit_i)
                pdt_pc_o = btb_target_i;
            else
                pdt_pc_o = if_pc_i + (cls.jal ? j_imm : b_imm);
        end
    end

endmodule

// File: rtl/bpu_top.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module bpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BPU_XLEN-1:0]   if_pc_i,
    input  logic [`BPU_XLEN-1:0]   if_inst_i,
    input  logic                   ex_branch_valid_i,
    input  logic                   ex_branch_taken_i,
    input  logic                   ex_pdt_true_i,
    input  logic [`BPU_XLEN-1:0]   ex_pc_i,
    input  logic [`BPU_HIST_W-1:0] ex_history_i,
    input  logic [`BPU_XLEN-1:0]   ex_target_i,
    input  logic [`BPU_XLEN-1:0]   ex_inst_i,
    output logic                   branch_or_not_o,
    output logic [`BPU_XLEN-1:0]   pdt_pc_o,
    output logic                   pdt_res_o,
    output logic [`BPU_HIST_W-1:0] history_o
);
    import bpu_pkg::*;

    ex_fb_t                             fb;
    bank_key_t [`BPU_NUM_BANKS-1:0]     lkp_key;
    bank_key_t [`BPU_NUM_BANKS-1:0]     upd_key;
    bank_hit_t [`BPU_NUM_BANKS-1:0]     lkp_hit;
    bank_hit_t [`BPU_NUM_BANKS-1:0]     upd_hit;
    bank_upd_t [`BPU_NUM_BANKS-1:0]     bank_upd;
    logic [`BPU_BIM_IDX_W-1:0]          bim_lkp_idx;
    logic [`BPU_BIM_IDX_W-1:0]          bim_upd_idx;
    logic                               dir_taken;
    logic                               btb_hit;
    logic [`BPU_XLEN-1:0]               btb_target;
    logic                               ras_nonempty;
    logic [`BPU_XLEN-1:0]               ras_top;

    assign fb = '{valid: ex_branch_valid_i, taken: ex_branch_taken_i,
                  pdt_true: ex_pdt_true_i, pc: ex_pc_i, hist: ex_history_i,
                  target: ex_target_i, inst: ex_inst_i};

    tage_hash u_tage_hash (
        .clk, .rst,
        .fb_i(fb), .if_pc_i,
        .lkp_key_o(lkp_key), .upd_key_o(upd_key),
        .bim_lkp_idx_o(bim_lkp_idx), .bim_upd_idx_o(bim_upd_idx),
        .history_o
    );

    for (genvar b = 0; b < `BPU_NUM_BANKS; b++) begin : g_bank
        tage_bank u_tage_bank (
            .clk, .rst,
            .lkp_key_i(lkp_key[b]), .upd_key_i(upd_key[b]), .upd_i(bank_upd[b]),
            .lkp_hit_o(lkp_hit[b]), .upd_hit_o(upd_hit[b])
        );
    end

    tage_select u_tage_select (
        .clk, .rst,
        .fb_i(fb),
        .bim_lkp_idx_i(bim_lkp_idx), .bim_upd_idx_i(bim_upd_idx),
        .lkp_hit_i(lkp_hit), .upd_hit_i(upd_hit),
        .upd_o(bank_upd), .dir_taken_o(dir_taken)
    );

    btb u_btb (.clk, .rst, .fb_i(fb), .if_pc_i, .hit_o(btb_hit), .target_o(btb_target));

    ras #(.DEPTH(`BPU_RAS_DEPTH)) u_ras (
        .clk, .rst, .fb_i(fb), .nonempty_o(ras_nonempty), .top_o(ras_top)
    );

    next_pc_sel u_next_pc_sel (
        .if_pc_i, .if_inst_i,
        .dir_taken_i(dir_taken),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .ras_nonempty_i(ras_nonempty), .ras_top_i(ras_top),
        .branch_or_not_o, .pdt_pc_o, .pdt_res_o
    );

endmodule

// File: tests/bpu_properties.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module bpu_properties (
    input logic                   clk,
    input logic                   rst,
    input logic [`BPU_XLEN-1:0]   if_pc_i,
    input logic [`BPU_XLEN-1:0]   if_inst_i,
    input logic                   ex_branch_valid_i,
    input logic                   ex_branch_taken_i,
    input logic                   branch_or_not_o,
    input logic [`BPU_XLEN-1:0]   pdt_pc_o,
    input logic                   pdt_res_o,
    input logic [`BPU_HIST_W-1:0] history_o
);
    logic is_ctrl_op;

    assign is_ctrl_op = (if_inst_i[6:0] == `BPU_OP_BRANCH) || (if_inst_i[6:0] == `BPU_OP_JAL) ||
                        (if_inst_i[6:0] == `BPU_OP_JALR);

    a_non_ctrl_quiet: assert property (@(posedge clk) disable iff (rst)
        !is_ctrl_op |-> !branch_or_not_o)
        else $error("control flag raised for a non-control word");

    // sequential fetch whenever not taken
    a_not_taken_seq: assert property (@(posedge clk) disable iff (rst)
        !pdt_res_o |-> (pdt_pc_o == if_pc_i + 32'd4))
        else $error("not-taken prediction does not point to pc plus four");

    a_hist_shift: assert property (@(posedge clk) disable iff (rst)
        ex_branch_valid_i |=>
            (history_o == {$past(history_o[`BPU_HIST_W-2:0]), $past(ex_branch_taken_i)}))
        else $error("global history did not shift in the resolved outcome");

endmodule

bind bpu_top bpu_properties u_bpu_properties (
    .clk(clk),
    .rst(rst),
    .if_pc_i(if_pc_i),
    .if_inst_i(if_inst_i),
    .ex_branch_valid_i(ex_branch_valid_i),
    .ex_branch_taken_i(ex_branch_taken_i),
    .branch_or_not_o(branch_or_not_o),
    .pdt_pc_o(pdt_pc_o),
    .pdt_res_o(pdt_res_o),
    .history_o(history_o)
);

// File: tests/bpu_tb.sv
`timescale 1ns/1ns
`include "bpu_defines.svh"

module bpu_tb;
    import bpu_pkg::*;

    localparam int  NUM_CYCLES = 6000;
    localparam time TIME_LIMIT = 64'd60000;   // ns, well above NUM_CYCLES periods

    logic                   clk;
    logic                   rst;
    logic [`BPU_XLEN-1:0]   if_pc_i;
    logic [`BPU_XLEN-1:0]   if_inst_i;
    logic                   ex_branch_valid_i;
    logic                   ex_branch_taken_i;
    logic                   ex_pdt_true_i;
    logic [`BPU_XLEN-1:0]   ex_pc_i;
    logic [`BPU_HIST_W-1:0] ex_history_i;
    logic [`BPU_XLEN-1:0]   ex_target_i;
    logic [`BPU_XLEN-1:0]   ex_inst_i;
    logic                   branch_or_not_o;
    logic [`BPU_XLEN-1:0]   pdt_pc_o;
    logic                   pdt_res_o;
    logic [`BPU_HIST_W-1:0] history_o;

    // reference model state
    logic [1:0]                m_bim     [1 << `BPU_BIM_IDX_W];
    logic [`BPU_TAG_W-1:0]     m_tag     [`BPU_NUM_BANKS][1 << `BPU_TAGE_IDX_W];
    logic [1:0]                m_ctr     [`BPU_NUM_BANKS][1 << `BPU_TAGE_IDX_W];
    logic                      m_btb_v   [1 << `BPU_BTB_IDX_W];
    logic [`BPU_BTB_TAG_W-1:0] m_btb_tag [1 << `BPU_BTB_IDX_W];
    logic [`BPU_XLEN-1:0]      m_btb_tgt [1 << `BPU_BTB_IDX_W];
    logic [`BPU_XLEN-1:0]      m_stack   [`BPU_RAS_DEPTH];
    int                        m_ptr;
    logic [`BPU_HIST_W-1:0]    m_hist;

    logic                 exp_ctrl;
    logic                 exp_res;
    logic [`BPU_XLEN-1:0] exp_pc;
    int                   cyc;

    bpu_top u_bpu_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        if (up)
            return (c == 2'b11) ? 2'b11 : c + 2'b01;
        return (c == 2'b00) ? 2'b00 : c - 2'b01;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic reset_model();
        foreach (m_bim[i]) m_bim[i] = 2'b01;
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            for (int i = 0; i < (1 << `BPU_TAGE_IDX_W); i++) begin
                m_tag[b][i] = '0;
                m_ctr[b][i] = 2'b01;
            end
        end
        foreach (m_btb_v[i]) m_btb_v[i] = 1'b0;
        m_ptr  = 0;
        m_hist = '0;
    endtask

    // small pool, bit 18 makes btb tags alias on the same index
    task automatic pick_pc(output logic [31:0] pc);
        pc = 32'h0000_0100 | ($urandom_range(0, 1) << 18) | ($urandom_range(0, 15) << 2);
    endtask

    task automatic gen_inst(output logic [31:0] w);
        int kind;
        w    = $urandom();
        kind = $urandom_range(0, 9);
        case (kind)
            0, 1: w[6:0] = 7'b0010011;          // alu op
            2, 3, 4, 5: w[6:0] = `BPU_OP_BRANCH;
            6: w[6:0] = `BPU_OP_JAL;
            7: begin
                w[6:0]   = `BPU_OP_JALR;        // call through register
                w[11:7]  = 5'd1;
            end
            8: begin
                w[6:0]   = `BPU_OP_JALR;        // return
                w[11:7]  = 5'd0;
                w[19:15] = 5'd1;
            end
            default: begin
                w[6:0]   = `BPU_OP_JALR;        // plain indirect jump
                w[11:7]  = 5'd0;
                w[19:15] = 5'd5;
            end
        endcase
    endtask

    task automatic predict(input logic [31:0] pc, input logic [31:0] w, output logic ctrl,
                           output logic res, output logic [31:0] npc);
        inst_class_t cls;
        bank_key_t   k;
        logic        dir;
        logic        bhit;
        logic [7:0]  bi;
        logic [31:0] b_imm;
        logic [31:0] j_imm;
        cls   = classify(w);
        bi    = pc[9:2];
        bhit  = m_btb_v[bi] && (m_btb_tag[bi] == pc[31:18]);
        dir   = m_bim[pc[`BPU_BIM_IDX_W:1]][1];
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            k = bank_hash(pc, m_hist, b);
            if (m_tag[b][k.idx][`BPU_TAG_W-1 -: `BPU_PTAG_W] == k.tag[`BPU_TAG_W-1 -: `BPU_PTAG_W])
                dir = m_ctr[b][k.idx][1];     // higher bank overrides
        end
        b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        ctrl  = cls.branch || cls.jal || cls.jalr;
        res   = 1'b0;
        npc   = pc + 32'd4;
        if (cls.ret) begin
            if (m_ptr > 0) begin
                res = 1'b1;
                npc = m_stack[m_ptr-1];
            end else if (bhit) begin
                res = 1'b1;
                npc = m_btb_tgt[bi];
            end
        end else if (cls.jalr) begin
            if (bhit) begin
                res = 1'b1;
                npc = m_btb_tgt[bi];
            end
        end else if (cls.jal || (cls.branch && dir)) begin
            res = 1'b1;
            npc = bhit ? m_btb_tgt[bi] : pc + (cls.jal ? j_imm : b_imm);
        end
    endtask

    task automatic update_model();
        inst_class_t cls;
        bank_key_t   k [`BPU_NUM_BANKS];
        int          prov;
        logic [7:0]  bi;
        cls  = classify(ex_inst_i);
        prov = -1;
        for (int b = 0; b < `BPU_NUM_BANKS; b++) begin
            k[b] = bank_hash(ex_pc_i, ex_history_i, b);
            if (m_tag[b][k[b].idx][`BPU_TAG_W-1 -: `BPU_PTAG_W] ==
                k[b].tag[`BPU_TAG_W-1 -: `BPU_PTAG_W])
                prov = b;
        end
        if (cls.branch) begin
            if (prov >= 0) begin
                if (ex_pdt_true_i)
                    m_ctr[prov][k[prov].idx] = sat_step(m_ctr[prov][k[prov].idx],
                                                        ex_branch_taken_i);
                else
                    m_ctr[prov][k[prov].idx] = ex_branch_taken_i ? 2'b11 : 2'b00;
            end
            if (!ex_pdt_true_i && prov + 1 < `BPU_NUM_BANKS) begin
                m_tag[prov+1][k[prov+1].idx] = k[prov+1].tag;
                m_ctr[prov+1][k[prov+1].idx] = ex_branch_taken_i ? 2'b10 : 2'b01;
            end
        end
        m_bim[ex_pc_i[`BPU_BIM_IDX_W:1]] = sat_step(m_bim[ex_pc_i[`BPU_BIM_IDX_W:1]],
                                                    ex_branch_taken_i);
        bi = ex_pc_i[9:2];
        if (ex_branch_taken_i && (cls.branch || cls.jal || cls.jalr)) begin
            m_btb_v[bi]   = 1'b1;
            m_btb_tag[bi] = ex_pc_i[31:18];
            m_btb_tgt[bi] = ex_target_i;
        end
        if (cls.call) begin
            if (m_ptr < `BPU_RAS_DEPTH) begin
                m_stack[m_ptr] = ex_pc_i + 32'd4;
                m_ptr++;
            end else begin
                m_stack[0] = ex_pc_i + 32'd4;   // full stack restarts at the bottom
                m_ptr = 1;
            end
        end else if (cls.ret && m_ptr > 0) begin
            m_ptr--;
        end
        m_hist = {m_hist[`BPU_HIST_W-2:0], ex_branch_taken_i};
    endtask

    task automatic drive_inputs();
        inst_class_t cls;
        logic [31:0] rnd;
        pick_pc(if_pc_i);
        gen_inst(if_inst_i);
        pick_pc(ex_pc_i);
        pick_pc(ex_target_i);
        gen_inst(ex_inst_i);
        cls = classify(ex_inst_i);
        rnd = $urandom();
        ex_branch_valid_i = ($urandom_range(0, 1) == 1);
        // branches lean by pc bit 2 with some noise
        ex_branch_taken_i = cls.jal || cls.jalr ||
                            (cls.branch && (ex_pc_i[2] ^ ($urandom_range(0, 7) == 0)));
        ex_pdt_true_i = ($urandom_range(0, 9) < 7);
        ex_history_i  = ($urandom_range(0, 3) == 0) ? rnd[`BPU_HIST_W-1:0] : m_hist;
    endtask

    initial begin
        rst               = 1'b1;
        if_pc_i           = '0;
        if_inst_i         = '0;
        ex_branch_valid_i = 1'b0;
        ex_branch_taken_i = 1'b0;
        ex_pdt_true_i     = 1'b0;
        ex_pc_i           = '0;
        ex_history_i      = '0;
        ex_target_i       = '0;
        ex_inst_i         = '0;
        void'($urandom(86));
        reset_model();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        cyc = 0;
        while (cyc < NUM_CYCLES && $time < TIME_LIMIT) begin
            if (cyc > 0)
                @(negedge clk);
            drive_inputs();
            #3;     // just before the rising edge
            predict(if_pc_i, if_inst_i, exp_ctrl, exp_res, exp_pc);
            check("branch_or_not_o", {31'd0, branch_or_not_o}, {31'd0, exp_ctrl});
            check("pdt_res_o", {31'd0, pdt_res_o}, {31'd0, exp_res});
            check("pdt_pc_o", pdt_pc_o, exp_pc);
            check("history_o", {16'd0, history_o}, {16'd0, m_hist});
            @(posedge clk);
            if (ex_branch_valid_i)
                update_model();
            cyc++;
        end
        if (cyc < NUM_CYCLES) begin
            $display("ERROR: time limit reached after %0d of %0d cycles", cyc, NUM_CYCLES);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+common
common/bpu_pkg.sv
tage/tage_hash.sv
tage/tage_bank.sv
tage/tage_select.sv
rtl/btb.sv
rtl/ras.sv
rtl/next_pc_sel.sv
rtl/bpu_top.sv
tests/bpu_properties.sv
tests/bpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
